// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Datapath widths
    localparam int ADDR_WIDTH  = 32;
    localparam int INSTR_WIDTH = 32;
    localparam int LINE_WIDTH  = 128;

    // Instructions handed to the instruction buffer per cycle
    localparam int FETCH_WIDTH = 2;

    // Fetch target queue entries
    localparam int FTQ_DEPTH = 4;
    localparam int FTQ_PTR_W = $clog2(FTQ_DEPTH);

    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h1c000000;

    // Line geometry, derived
    localparam int WORDS_PER_LINE = LINE_WIDTH / INSTR_WIDTH;
    localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);
    localparam int BYTE_OFFSET_W  = $clog2(INSTR_WIDTH / 8);
    localparam int LINE_OFFSET_W  = WORD_IDX_W + BYTE_OFFSET_W;

    // Block length field, holds 1 or 2
    localparam int BLK_LEN_W = 2;

    // Fetch unit FSM
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_RESP = 2'd1,
        // Request killed by a flush, response still to come
        DRAIN     = 2'd2
    } fetch_state_e;

    // Per-instruction exception code
    typedef enum logic {
        NONE = 1'b0,
        ADEF = 1'b1
    } excp_code_e;

endpackage

`default_nettype wire

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,

    // Redirect from the back end
    input  logic                              flush_i,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0]  redirect_pc_i,

    // Fetch target queue
    input  logic                              ftq_full_i,
    output logic                              blk_valid_o,
    output logic [fetch_pkg::ADDR_WIDTH-1:0]  blk_pc_o,
    output logic [fetch_pkg::BLK_LEN_W-1:0]   blk_len_o
);

    import fetch_pkg::*;

    logic [ADDR_WIDTH-1:0] pc_q;
    logic [ADDR_WIDTH-1:0] pc_d;
    logic [ADDR_WIDTH-1:0] pc_aligned;
    logic                  fetch_en_q;
    logic                  pc_misaligned;
    logic                  pc_last_word;

    // Block formation starts one cycle after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
        end
    end

    assign pc_misaligned = |pc_q[BYTE_OFFSET_W-1:0];
    assign pc_last_word  = (pc_q[LINE_OFFSET_W-1:BYTE_OFFSET_W] ==
                            WORD_IDX_W'(WORDS_PER_LINE - 1));

    // Blocks never cross a line; a bad PC goes out alone
    assign blk_len_o = (pc_misaligned || pc_last_word) ? BLK_LEN_W'(1) : BLK_LEN_W'(2);
    assign blk_pc_o  = pc_q;

    // Full is the only back-pressure toward the PC
    assign blk_valid_o = fetch_en_q && !ftq_full_i && !flush_i;

    assign pc_aligned = {pc_q[ADDR_WIDTH-1:BYTE_OFFSET_W], {BYTE_OFFSET_W{1'b0}}};

    always_comb begin
        if (flush_i) begin
            pc_d = redirect_pc_i;
        end else if (!blk_valid_o) begin
            pc_d = pc_q;
        end else begin
            // A misaligned PC moves on to the next aligned word
            pc_d = pc_aligned + (ADDR_WIDTH'(blk_len_o) << BYTE_OFFSET_W);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // A block ends within its own line
    a_blk_in_line : assert property (
        @(posedge clk) disable iff (!rst_n)
        blk_valid_o |-> ((WORD_IDX_W+1)'(pc_q[LINE_OFFSET_W-1:BYTE_OFFSET_W]) +
                         (WORD_IDX_W+1)'(blk_len_o) <= (WORD_IDX_W+1)'(WORDS_PER_LINE))
    );

endmodule

`default_nettype wire

// ==== source/fetch_target_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_target_queue (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              flush_i,

    // Write side, from fetch control
    input  logic                              push_i,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0]  push_pc_i,
    input  logic [fetch_pkg::BLK_LEN_W-1:0]   push_len_i,
    output logic                              full_o,

    // Read side, toward the fetch unit
    input  logic                              pop_i,
    output logic                              head_valid_o,
    output logic [fetch_pkg::ADDR_WIDTH-1:0]  head_pc_o,
    output logic [fetch_pkg::BLK_LEN_W-1:0]   head_len_o
);

    import fetch_pkg::*;

    logic [ADDR_WIDTH-1:0] pc_mem  [FTQ_DEPTH];
    logic [BLK_LEN_W-1:0]  len_mem [FTQ_DEPTH];

    logic [FTQ_PTR_W-1:0]  wr_ptr_q;
    logic [FTQ_PTR_W-1:0]  rd_ptr_q;
    logic [FTQ_PTR_W:0]    count_q;
    logic                  do_push;
    logic                  do_pop;

    assign full_o       = (count_q == (FTQ_PTR_W+1)'(FTQ_DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_pc_o    = pc_mem[rd_ptr_q];
    assign head_len_o   = len_mem[rd_ptr_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && head_valid_o;

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr_q]  <= push_pc_i;
            len_mem[wr_ptr_q] <= push_len_i;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Every queued block is on the wrong path
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n) push_i |-> !full_o
    );

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!rst_n) pop_i |-> head_valid_o
    );

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic                                                     flush_i,
    input  logic                                                     stall_i,

    // Fetch target queue head
    input  logic                                                     ftq_valid_i,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0]                         ftq_pc_i,
    input  logic [fetch_pkg::BLK_LEN_W-1:0]                          ftq_len_i,
    output logic                                                     ftq_accept_o,

    // Instruction cache
    output logic                                                     icache_req_o,
    output logic [fetch_pkg::ADDR_WIDTH-1:0]                         icache_addr_o,
    input  logic                                                     icache_valid_i,
    input  logic [fetch_pkg::LINE_WIDTH-1:0]                         icache_data_i,

    // Instruction buffer
    output logic [fetch_pkg::FETCH_WIDTH-1:0]                        instr_valid_o,
    output logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::ADDR_WIDTH-1:0]  instr_pc_o,
    output logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::INSTR_WIDTH-1:0] instr_data_o,
    output fetch_pkg::excp_code_e [fetch_pkg::FETCH_WIDTH-1:0]       instr_excp_o
);

    import fetch_pkg::*;

    fetch_state_e           state_q;
    fetch_state_e           state_d;

    // Block waiting for its line
    logic [ADDR_WIDTH-1:0]  blk_pc_q;
    logic [BLK_LEN_W-1:0]   blk_len_q;

    logic                   out_held;
    logic                   resp_live;

    logic [FETCH_WIDTH-1:0]                  slot_valid;
    logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]  slot_pc;
    logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] slot_data;
    excp_code_e [FETCH_WIDTH-1:0]            slot_excp;

    // Stalled slots still own the output register
    assign out_held = stall_i && |instr_valid_o;

    assign ftq_accept_o  = (state_q == IDLE) && ftq_valid_i && !flush_i && !out_held;
    assign icache_req_o  = ftq_accept_o;
    assign icache_addr_o = {ftq_pc_i[ADDR_WIDTH-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};

    // Response for a block that is still wanted
    assign resp_live = (state_q == WAIT_RESP) && icache_valid_i && !flush_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ftq_accept_o) begin
                    state_d = WAIT_RESP;
                end
            end
            WAIT_RESP: begin
                if (icache_valid_i) begin
                    state_d = IDLE;
                end else if (flush_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (icache_valid_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ftq_accept_o) begin
            blk_pc_q  <= ftq_pc_i;
            blk_len_q <= ftq_len_i;
        end
    end

    // Pick the words at PC[3:2] and the one after it
    always_comb begin : extract
        logic [WORD_IDX_W-1:0] word_idx;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            word_idx      = blk_pc_q[LINE_OFFSET_W-1:BYTE_OFFSET_W] + WORD_IDX_W'(i);
            slot_valid[i] = (BLK_LEN_W'(i) < blk_len_q);
            slot_pc[i]    = blk_pc_q + (ADDR_WIDTH'(i) << BYTE_OFFSET_W);
            slot_data[i]  = icache_data_i[word_idx*INSTR_WIDTH +: INSTR_WIDTH];
            slot_excp[i]  = (|slot_pc[i][BYTE_OFFSET_W-1:0]) ? ADEF : NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid_o <= '0;
        end else if (flush_i) begin
            instr_valid_o <= '0;
        end else if (resp_live) begin
            instr_valid_o <= slot_valid;
        end else if (!stall_i) begin
            // Consumed this cycle
            instr_valid_o <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_live) begin
            instr_pc_o   <= slot_pc;
            instr_data_o <= slot_data;
            instr_excp_o <= slot_excp;
        end
    end

    // The cache answers only a request still outstanding
    a_resp_expected : assert property (
        @(posedge clk) disable iff (!rst_n) icache_valid_i |-> (state_q != IDLE)
    );

    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall_i && |instr_valid_o && !flush_i) |=>
            ($stable(instr_valid_o) && $stable(instr_pc_o) &&
             $stable(instr_data_o) && $stable(instr_excp_o))
    );

endmodule

`default_nettype wire

// ==== source/fetch_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend (
    input  logic                                                     clk,
    input  logic                                                     rst_n,

    // Back end redirect
    input  logic                                                     flush_i,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0]                         redirect_pc_i,

    // Instruction buffer back-pressure
    input  logic                                                     stall_i,

    // Instruction cache port
    output logic                                                     icache_req_o,
    output logic [fetch_pkg::ADDR_WIDTH-1:0]                         icache_addr_o,
    input  logic                                                     icache_valid_i,
    input  logic [fetch_pkg::LINE_WIDTH-1:0]                         icache_data_i,

    // Delivered instructions
    output logic [fetch_pkg::FETCH_WIDTH-1:0]                        instr_valid_o,
    output logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::ADDR_WIDTH-1:0]  instr_pc_o,
    output logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::INSTR_WIDTH-1:0] instr_data_o,
    output fetch_pkg::excp_code_e [fetch_pkg::FETCH_WIDTH-1:0]       instr_excp_o
);

    import fetch_pkg::*;

    // Control to queue
    logic                  blk_valid;
    logic [ADDR_WIDTH-1:0] blk_pc;
    logic [BLK_LEN_W-1:0]  blk_len;
    logic                  ftq_full;

    // Queue to fetch unit
    logic                  ftq_valid;
    logic [ADDR_WIDTH-1:0] ftq_pc;
    logic [BLK_LEN_W-1:0]  ftq_len;
    logic                  ftq_accept;

    fetch_ctrl u_fetch_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .ftq_full_i    (ftq_full),
        .blk_valid_o   (blk_valid),
        .blk_pc_o      (blk_pc),
        .blk_len_o     (blk_len)
    );

    fetch_target_queue u_fetch_target_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .push_i       (blk_valid),
        .push_pc_i    (blk_pc),
        .push_len_i   (blk_len),
        .full_o       (ftq_full),
        .pop_i        (ftq_accept),
        .head_valid_o (ftq_valid),
        .head_pc_o    (ftq_pc),
        .head_len_o   (ftq_len)
    );

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush_i),
        .stall_i        (stall_i),
        .ftq_valid_i    (ftq_valid),
        .ftq_pc_i       (ftq_pc),
        .ftq_len_i      (ftq_len),
        .ftq_accept_o   (ftq_accept),
        .icache_req_o   (icache_req_o),
        .icache_addr_o  (icache_addr_o),
        .icache_valid_i (icache_valid_i),
        .icache_data_i  (icache_data_i),
        .instr_valid_o  (instr_valid_o),
        .instr_pc_o     (instr_pc_o),
        .instr_data_o   (instr_data_o),
        .instr_excp_o   (instr_excp_o)
    );

endmodule

`default_nettype wire

// ==== verif/tb_fetch_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_frontend;

    import fetch_pkg::*;

    localparam int                     CLK_HALF     = 50;
    localparam int                     DRIVE_DELAY  = 10;
    localparam int                     RESET_CYCLES = 8;
    localparam int                     MAX_LAT      = 4;
    localparam logic [31:0]            SEED         = 32'h148952e6;
    localparam logic [INSTR_WIDTH-1:0] DATA_KEY     = 32'hA5A5_0000;

    logic                                    clk = 1'b0;
    logic                                    rst_n;
    logic                                    flush_i;
    logic [ADDR_WIDTH-1:0]                   redirect_pc_i;
    logic                                    stall_i;
    logic                                    icache_req_o;
    logic [ADDR_WIDTH-1:0]                   icache_addr_o;
    logic                                    icache_valid_i;
    logic [LINE_WIDTH-1:0]                   icache_data_i;
    logic [FETCH_WIDTH-1:0]                  instr_valid_o;
    logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]  instr_pc_o;
    logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] instr_data_o;
    excp_code_e [FETCH_WIDTH-1:0]            instr_excp_o;

    // Trace contents with stimulus keyed by cycle
    logic                  stim_stall    [int];
    logic                  stim_flush    [int];
    logic [ADDR_WIDTH-1:0] stim_redirect [int];
    logic [ADDR_WIDTH-1:0] exp_pc_q      [$];
    excp_code_e            exp_excp_q    [$];
    int                    last_cycle;
    int                    cycle_limit;
    int                    cyc;

    // Cache model state for the single outstanding request
    logic                  resp_pending;
    int                    resp_wait;
    logic [ADDR_WIDTH-1:0] resp_addr;

    always #CLK_HALF clk = ~clk;

    fetch_frontend dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush_i),
        .redirect_pc_i  (redirect_pc_i),
        .stall_i        (stall_i),
        .icache_req_o   (icache_req_o),
        .icache_addr_o  (icache_addr_o),
        .icache_valid_i (icache_valid_i),
        .icache_data_i  (icache_data_i),
        .instr_valid_o  (instr_valid_o),
        .instr_pc_o     (instr_pc_o),
        .instr_data_o   (instr_data_o),
        .instr_excp_o   (instr_excp_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] expected,
                              input logic [ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_instr(input string name, input logic [INSTR_WIDTH-1:0] expected,
                               input logic [INSTR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_excp(input string name, input excp_code_e expected,
                              input excp_code_e actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s expected %s, actual %s",
                                $time, name, expected.name(), actual.name()));
        end
    endtask

    // Every memory word is its own address scrambled with a key
    function automatic logic [INSTR_WIDTH-1:0] word_data(input logic [ADDR_WIDTH-1:0] addr);
        return {addr[ADDR_WIDTH-1:2], 2'b00} ^ DATA_KEY;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] line_data(input logic [ADDR_WIDTH-1:0] line_addr);
        logic [LINE_WIDTH-1:0] data;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            data[w*INSTR_WIDTH +: INSTR_WIDTH] = word_data(line_addr + ADDR_WIDTH'(w * 4));
        end
        return data;
    endfunction

    task automatic read_trace();
        int                    fd;
        int                    cycle;
        int                    stall;
        int                    flush;
        int                    excp;
        int                    ch;
        logic [7:0]            tag;
        logic [ADDR_WIDTH-1:0] addr;
        fd = $fopen("verif/fetch_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open verif/fetch_trace.txt");
        end
        last_cycle = 0;
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (tag == "S") begin
                if ($fscanf(fd, "%d %d %d %h", cycle, stall, flush, addr) != 4) begin
                    abort_run("Malformed stimulus record in trace file");
                end
                stim_stall[cycle]    = (stall != 0);
                stim_flush[cycle]    = (flush != 0);
                stim_redirect[cycle] = addr;
                if (cycle > last_cycle) begin
                    last_cycle = cycle;
                end
            end else if (tag == "E") begin
                if ($fscanf(fd, "%h %d", addr, excp) != 2) begin
                    abort_run("Malformed expected record in trace file");
                end
                exp_pc_q.push_back(addr);
                exp_excp_q.push_back((excp != 0) ? ADEF : NONE);
            end else begin
                abort_run($sformatf("Unknown record type '%c' in trace file", tag));
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_stimulus(input int c);
        if (stim_stall.exists(c)) begin
            stall_i       = stim_stall[c];
            flush_i       = stim_flush[c];
            redirect_pc_i = stim_redirect[c];
        end else begin
            // Unlisted cycles stall with no redirect
            stall_i       = 1'b1;
            flush_i       = 1'b0;
            redirect_pc_i = '0;
        end
        icache_valid_i = 1'b0;
        if (resp_pending) begin
            resp_wait--;
            if (resp_wait == 0) begin
                icache_valid_i = 1'b1;
                icache_data_i  = line_data(resp_addr);
                resp_pending   = 1'b0;
            end
        end
    endtask

    task automatic capture_request();
        if (icache_req_o) begin
            if (resp_pending) begin
                abort_run("Cache request issued while another request is outstanding");
            end
            if (icache_addr_o[LINE_OFFSET_W-1:0] != '0) begin
                abort_run($sformatf("Cache request address %h is not line aligned",
                                    icache_addr_o));
            end
            resp_pending = 1'b1;
            resp_wait    = 1 + int'($urandom % MAX_LAT);
            resp_addr    = icache_addr_o;
        end
    endtask

    // A slot is taken on a cycle with valid high and stall low
    task automatic check_slots();
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            if (instr_valid_o[s] && !stall_i) begin
                if (exp_pc_q.size() == 0) begin
                    abort_run($sformatf(
                        "Slot %0d delivered PC %h after the expected stream ended",
                        s, instr_pc_o[s]));
                end
                check_addr($sformatf("instr_pc_o[%0d]", s), exp_pc_q[0], instr_pc_o[s]);
                check_instr($sformatf("instr_data_o[%0d]", s), word_data(exp_pc_q[0]),
                            instr_data_o[s]);
                check_excp($sformatf("instr_excp_o[%0d]", s), exp_excp_q[0], instr_excp_o[s]);
                void'(exp_pc_q.pop_front());
                void'(exp_excp_q.pop_front());
            end
        end
    endtask

    initial begin : main
        rst_n          = 1'b0;
        flush_i        = 1'b0;
        redirect_pc_i  = '0;
        stall_i        = 1'b1;
        icache_valid_i = 1'b0;
        icache_data_i  = '0;
        resp_pending   = 1'b0;
        resp_wait      = 0;
        resp_addr      = '0;
        cyc            = 0;
        void'($urandom(SEED));
        read_trace();
        // Room for a full queue behind the slowest cache
        cycle_limit = last_cycle + 5 * FTQ_DEPTH * MAX_LAT;
        repeat (RESET_CYCLES) @(posedge clk);
        while (cyc <= cycle_limit && !(cyc > last_cycle && exp_pc_q.size() == 0)) begin
            #DRIVE_DELAY;
            // Reset released in cycle 0
            rst_n = 1'b1;
            apply_stimulus(cyc);
            @(negedge clk);
            capture_request();
            check_slots();
            @(posedge clk);
            cyc++;
        end
        if (exp_pc_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf(
                "Delivery stalled, %0d expected instructions missing after %0d cycles",
                exp_pc_q.size(), cyc));
        end
    end

endmodule

`default_nettype wire

// ==== verif/fetch_trace.txt ====
# S <cycle> <stall> <flush> <redirect_pc hex> : inputs for that cycle only, other cycles stall=1
# E <pc hex> <excp 0=NONE 1=ADEF> : next instruction expected, in delivery order
# Sequential fetch from reset, one block taken per stall-low cycle
S 10 0 0 00000000
S 18 0 0 00000000
S 26 0 0 00000000
S 34 0 0 00000000
S 42 0 0 00000000
E 1c000000 0
E 1c000004 0
E 1c000008 0
E 1c00000c 0
E 1c000010 0
E 1c000014 0
E 1c000018 0
E 1c00001c 0
E 1c000020 0
E 1c000024 0
# Flush with a request outstanding, redirect to the last word of a line
S 43 1 1 1c00010c
S 55 0 0 00000000
S 63 0 0 00000000
S 71 0 0 00000000
E 1c00010c 0
E 1c000110 0
E 1c000114 0
E 1c000118 0
E 1c00011c 0
# Flush over held outputs, misaligned redirect
S 79 1 1 1c000202
S 90 0 0 00000000
S 98 0 0 00000000
S 106 0 0 00000000
S 114 0 0 00000000
E 1c000202 1
E 1c000204 0
E 1c000208 0
E 1c00020c 0
E 1c000210 0
E 1c000214 0
S 115 1 1 1c000408
S 127 0 0 00000000
S 135 0 0 00000000
E 1c000408 0
E 1c00040c 0
E 1c000410 0
E 1c000414 0
# Misaligned PC in the last word of a line
S 137 1 1 1c00050d
S 149 0 0 00000000
S 157 0 0 00000000
S 160 1 0 00000000
E 1c00050d 1
E 1c000510 0
E 1c000514 0

// ==== compile.f ====
source/fetch_pkg.sv
source/fetch_ctrl.sv
source/fetch_target_queue.sv
source/fetch_unit.sv
source/fetch_frontend.sv
verif/tb_fetch_frontend.sv

// ==== Makefile ====
TOP = tb_fetch_frontend

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module $(TOP) -f compile.f

run: compile
	-./obj_dir/V$(TOP) > run.log 2>&1
	@cat run.log
	@if grep -qF '*** TEST FAILED ***' run.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -qF '*** TEST PASSED ***' run.log; then \
		echo "No pass message found in run.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir run.log
